/* sources.f */
+incdir+hdl
+incdir+dv
hdl/cipher_pkg.sv
hdl/string_loader.sv
hdl/cipher_sequencer.sv
hdl/caesar_shift.sv
hdl/result_assembler.sv
hdl/cipher_top.sv
dv/cipher_tb.sv

/* dv/cipher_tb_model.svh */
`ifndef CIPHER_TB_MODEL_SVH
`define CIPHER_TB_MODEL_SVH

// Loaded string as the testbench expects it, slot 0 in the top bits.
logic [`CIPHER_STR_W-1:0] model_plain;

// Slots filled since the last reset.
int model_count;

// Empty string, nothing loaded.
function automatic void model_clear();
	model_plain = '0;
	model_count = 0;
endfunction

// One load strobe, dropped once all slots hold a character.
function automatic void model_load(input logic [`CIPHER_CHAR_W-1:0] c);
	if (model_count < `CIPHER_STR_LEN)
	begin
		model_plain[`CIPHER_STR_W-1-`CIPHER_CHAR_W*model_count -: `CIPHER_CHAR_W] = c;
		model_count = model_count + 1;
	end
endfunction

// Caesar rule on one code.
// Letters are 1 to 26, everything else is returned as it came in.
function automatic logic [`CIPHER_CHAR_W-1:0] model_shift_char(
	input logic [`CIPHER_CHAR_W-1:0] c, input int amount, input logic dec);
	int code;
	int s;
	int p;
	code = c;
	s = amount % `CIPHER_ALPHA;
	if (code < 1 || code > `CIPHER_ALPHA)
		return c;
	p = code - 1;
	if (dec)
		p = (p - s + `CIPHER_ALPHA) % `CIPHER_ALPHA;
	else
		p = (p + s) % `CIPHER_ALPHA;
	p = p + 1;
	return p[`CIPHER_CHAR_W-1:0];
endfunction

// Whole string, slot by slot.
function automatic logic [`CIPHER_STR_W-1:0] model_cipher(
	input logic [`CIPHER_STR_W-1:0] plain, input int amount, input logic dec);
	logic [`CIPHER_STR_W-1:0] res;
	int i;
	res = '0;
	for (i = 0; i < `CIPHER_STR_LEN; i++)
		res[`CIPHER_STR_W-1-`CIPHER_CHAR_W*i -: `CIPHER_CHAR_W] =
			model_shift_char(plain[`CIPHER_STR_W-1-`CIPHER_CHAR_W*i -: `CIPHER_CHAR_W],
				amount, dec);
	return res;
endfunction

`endif

/* dv/cipher_tb.sv */
`default_nettype none

`include "cipher_settings.svh"

module cipher_tb;
	import cipher_pkg::*;

	// Random strings with two runs each, and encode then decode pairs.
	localparam int num_runs = 40;
	localparam int num_trips = 8;
	// Cycles allowed for one run, and for the reset and loads around it.
	localparam int run_cycles = 20;
	localparam int load_cycles = 20;
	localparam int clock_period = 100;
	localparam int drive_delay = 10;
	localparam int total_runs = 2 * num_runs + 2 * num_trips;
	localparam int watchdog_time =
		(total_runs * run_cycles + (total_runs + 1) * load_cycles) * clock_period;

	logic clock;
	logic resetn;
	logic load;
	logic go;
	logic decode;
	char_t char_in;
	char_t shift;
	method_t method;
	logic busy;
	logic done;
	str_t string_out;

	integer seed;

	`include "cipher_tb_model.svh"

	cipher_top UUT
	(
		.clock      (clock),
		.resetn     (resetn),
		.load       (load),
		.go         (go),
		.decode     (decode),
		.char_in    (char_in),
		.shift      (shift),
		.method     (method),
		.busy       (busy),
		.done       (done),
		.string_out (string_out)
	);

	initial
	begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	// Ends a run that stalls.
	initial
	begin
		#(watchdog_time);
		$display("Watchdog timeout, the simulation ran past its time limit.");
		report_failure();
	end

	// Inputs change a little after the rising edge.
	task automatic next_cycle();
		@(posedge clock);
		#(drive_delay);
	endtask

	task automatic report_failure();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at the first failure.");
	endtask

	task automatic check_str(input string name, input logic [`CIPHER_STR_W-1:0] expected,
		input logic [`CIPHER_STR_W-1:0] actual);
		assert (actual === expected)
		else
		begin
			$display("ERR time %0t %s expected %h actual %h", $time, name, expected, actual);
			report_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		assert (actual === expected)
		else
		begin
			$display("ERR time %0t %s expected %b actual %b", $time, name, expected, actual);
			report_failure();
		end
	endtask

	// Any of the 32 codes.
	function automatic char_t random_char();
		integer r;
		r = $random(seed);
		return r[4:0];
	endfunction

	// A letter code from 1 to 26.
	function automatic char_t random_letter();
		integer r;
		r = $random(seed);
		r = (r & 32'h7fff_ffff) % `CIPHER_ALPHA + 1;
		return r[4:0];
	endfunction

	// Two cycles of reset, then one idle cycle.
	task automatic apply_reset();
		resetn = 1'b0;
		load = 1'b0;
		go = 1'b0;
		method = method_plain;
		repeat (2) next_cycle();
		resetn = 1'b1;
		model_clear();
		next_cycle();
	endtask

	// One load strobe with the plain view checked after the edge.
	task automatic load_char(input char_t c);
		load = 1'b1;
		char_in = c;
		model_load(c);
		next_cycle();
		load = 1'b0;
		check_str("string_out", model_plain, string_out);
	endtask

	// Codes 00, 10 and 11 show the plain string.
	// The Caesar view is checked only when a result is known.
	task automatic check_views(input logic [`CIPHER_STR_W-1:0] cipher_exp, input bit with_cipher);
		int m;
		for (m = 0; m < 4; m++)
		begin
			method = method_t'(m);
			next_cycle();
			if (method != method_caesar)
				check_str("string_out", model_plain, string_out);
			else if (with_cipher)
				check_str("string_out", cipher_exp, string_out);
		end
		method = method_plain;
	endtask

	// One go with an optional second go and loads while busy.
	task automatic run_cipher(input logic dec, input char_t sh, input bit disturb,
		output logic [`CIPHER_STR_W-1:0] result);
		logic [`CIPHER_STR_W-1:0] expected;
		int cycles;
		bit finished;
		expected = model_cipher(model_plain, sh, dec);
		go = 1'b1;
		decode = dec;
		shift = sh;
		next_cycle();
		check_bit("busy", 1'b1, busy);
		cycles = 0;
		finished = 1'b0;
		while (!finished && cycles < run_cycles)
		begin
			// Disturbance lands on every edge of the busy window.
			if (disturb && cycles < 6)
			begin
				go = 1'b1;
				decode = ~dec;
				shift = random_char();
				load = 1'b1;
				char_in = random_char();
				model_load(char_in);
			end
			else
			begin
				go = 1'b0;
				load = 1'b0;
			end
			next_cycle();
			cycles++;
			if (done)
				finished = 1'b1;
			else
				check_bit("busy", 1'b1, busy);
		end
		go = 1'b0;
		load = 1'b0;
		if (!finished)
		begin
			$display("Run timed out, done never rose after go.");
			report_failure();
		end
		assert (cycles == 6)
		else
		begin
			$display("ERR time %0t done latency expected 6 actual %0d", $time, cycles);
			report_failure();
		end
		check_bit("busy", 1'b0, busy);
		method = method_caesar;
		next_cycle();
		check_str("string_out", expected, string_out);
		result = string_out;
		method = method_plain;
	endtask

	initial
	begin : main
		logic [`CIPHER_STR_W-1:0] result;
		logic [`CIPHER_STR_W-1:0] original;
		integer r;
		int count;
		int i;
		int k;
		bit disturb;
		logic dec;
		char_t sh;
		seed = 23557;
		resetn = 1'b0;
		load = 1'b0;
		go = 1'b0;
		decode = 1'b0;
		char_in = '0;
		shift = '0;
		method = method_plain;
		model_clear();

		// Idle outputs after reset.
		apply_reset();
		check_bit("busy", 1'b0, busy);
		check_bit("done", 1'b0, done);
		check_str("string_out", '0, string_out);

		// Seven loads where the last two must be dropped.
		for (i = 0; i < 7; i++)
			load_char(random_char());
		check_views('0, 1'b0);

		// Random strings, directions and shifts.
		for (k = 0; k < num_runs; k++)
		begin
			apply_reset();
			r = $random(seed);
			disturb = (r[1:0] == 2'b00);
			count = r[4:2];
			if (count > `CIPHER_STR_LEN)
				count = `CIPHER_STR_LEN;
			// Leave room so loads during the run still land.
			if (disturb && count > 3)
				count = 3;
			for (i = 0; i < count; i++)
				load_char(random_char());
			check_views('0, 1'b0);
			dec = r[5];
			sh = random_char();
			run_cipher(dec, sh, disturb, result);
			check_views(result, 1'b1);
			// A second run on the same string without reset.
			// Done has to drop on the go and rise again.
			sh = random_char();
			run_cipher(~dec, sh, 1'b0, result);
			check_views(result, 1'b1);
		end

		// Encode, reload the result, decode with the same shift.
		for (k = 0; k < num_trips; k++)
		begin
			apply_reset();
			for (i = 0; i < `CIPHER_STR_LEN; i++)
				load_char(random_letter());
			original = model_plain;
			sh = random_char();
			run_cipher(1'b0, sh, 1'b0, result);
			apply_reset();
			for (i = 0; i < `CIPHER_STR_LEN; i++)
				load_char(result[`CIPHER_STR_W-1-`CIPHER_CHAR_W*i -: `CIPHER_CHAR_W]);
			run_cipher(1'b1, sh, 1'b0, result);
			check_str("round trip string_out", original, result);
		end

		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/cipher_top.sv */
`default_nettype none

module cipher_top
(
	input  logic                clock,
	input  logic                resetn,
	input  logic                load,
	input  logic                go,
	input  logic                decode,
	input  cipher_pkg::char_t   char_in,
	input  cipher_pkg::char_t   shift,
	input  cipher_pkg::method_t method,
	output logic                busy,
	output logic                done,
	output cipher_pkg::str_t    string_out
);
	import cipher_pkg::*;

	// Loaded string, the plain view and the run source.
	str_t plain_str;

	// Sequencer to shifter.
	logic issue_valid;
	slot_t issue_slot;
	char_t issue_char;
	opcode_t issue_op;
	char_t issue_amount;

	// Run start pulse to the assembler.
	logic start;

	// Shifter to assembler.
	logic out_valid;
	slot_t out_slot;
	char_t out_char;

	// Character entry.
	string_loader u_loader
	(
		.clock   (clock),
		.resetn  (resetn),
		.load    (load),
		.char_in (char_in),
		.str     (plain_str)
	);

	// Decode role, turns go into a stream of slots.
	cipher_sequencer u_sequencer
	(
		.clock        (clock),
		.resetn       (resetn),
		.go           (go),
		.decode       (decode),
		.shift        (shift),
		.str          (plain_str),
		.busy         (busy),
		.start        (start),
		.issue_valid  (issue_valid),
		.issue_slot   (issue_slot),
		.issue_char   (issue_char),
		.issue_op     (issue_op),
		.issue_amount (issue_amount)
	);

	// Execute role.
	caesar_shift u_shift
	(
		.clock     (clock),
		.resetn    (resetn),
		.in_valid  (issue_valid),
		.in_slot   (issue_slot),
		.in_char   (issue_char),
		.op        (issue_op),
		.amount    (issue_amount),
		.out_valid (out_valid),
		.out_slot  (out_slot),
		.out_char  (out_char)
	);

	// Result role.
	result_assembler u_result
	(
		.clock      (clock),
		.resetn     (resetn),
		.start      (start),
		.wr_valid   (out_valid),
		.wr_slot    (out_slot),
		.wr_char    (out_char),
		.plain      (plain_str),
		.method     (method),
		.done       (done),
		.string_out (string_out)
	);

endmodule

`default_nettype wire

/* hdl/result_assembler.sv */
`default_nettype none

`include "cipher_settings.svh"

module result_assembler
(
	input  logic                clock,
	input  logic                resetn,
	input  logic                start,
	input  logic                wr_valid,
	input  cipher_pkg::slot_t   wr_slot,
	input  cipher_pkg::char_t   wr_char,
	input  cipher_pkg::str_t    plain,
	input  cipher_pkg::method_t method,
	output logic                done,
	output cipher_pkg::str_t    string_out
);
	import cipher_pkg::*;

	// Slot whose write completes a run.
	localparam slot_t last_slot = slot_t'(`CIPHER_STR_LEN - 1);

	// Cipher result, one slot per shifted character.
	str_t result;

	// Done drops at the start of a run and rises with the last slot.
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			result <= '0;
			done <= 1'b0;
		end
		else
		begin
			if (start)
				done <= 1'b0;
			if (wr_valid)
			begin
				result[wr_slot] <= wr_char;
				if (wr_slot == last_slot)
					done <= 1'b1;
			end
		end
	end

	// Live view select.
	// Vigenere and spare codes fall back to the plain string.
	always_comb
	begin
		if (method == method_caesar)
			string_out = result;
		else
			string_out = plain;
	end

	// Slots from the shifter stay inside the string.
	wr_slot_in_range: assert property (@(posedge clock) disable iff (!resetn)
		wr_valid |-> (wr_slot <= last_slot));

endmodule

`default_nettype wire

/* hdl/caesar_shift.sv */
`default_nettype none

`include "cipher_settings.svh"

module caesar_shift
(
	input  logic                clock,
	input  logic                resetn,
	input  logic                in_valid,
	input  cipher_pkg::slot_t   in_slot,
	input  cipher_pkg::char_t   in_char,
	input  cipher_pkg::opcode_t op,
	input  cipher_pkg::char_t   amount,
	output logic                out_valid,
	output cipher_pkg::slot_t   out_slot,
	output cipher_pkg::char_t   out_char
);
	import cipher_pkg::*;

	// Alphabet size, one bit wider than a character for the sum.
	localparam logic [5:0] alpha = 6'(`CIPHER_ALPHA);

	// Code of the letter z.
	localparam char_t last_letter = char_t'(`CIPHER_ALPHA);

	logic is_letter;
	logic [5:0] pos;
	logic [5:0] amt;
	logic [5:0] sum;
	logic [5:0] rot;
	char_t shifted;

	// Letters are 1 to 26.
	assign is_letter = (in_char != '0) && (in_char <= last_letter);

	// Zero-based position in the alphabet, and the widened shift.
	assign pos = {1'b0, in_char} - 6'd1;
	assign amt = {1'b0, amount};
	assign sum = pos + amt;

	// Rotate with wraparound, the amount is already below 26.
	always_comb
	begin
		if (op == op_encode)
			rot = (sum >= alpha) ? sum - alpha : sum;
		else
			rot = (pos >= amt) ? pos - amt : pos + alpha - amt;
	end

	// Back to a one-based code, other codes pass through.
	assign shifted = is_letter ? rot[4:0] + 5'd1 : in_char;

	always_ff @(posedge clock)
	begin
		if (!resetn)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	// Result travels with its slot.
	always_ff @(posedge clock)
	begin
		if (in_valid)
		begin
			out_slot <= in_slot;
			out_char <= shifted;
		end
	end

	// A letter in gives a letter out one cycle later.
	letter_kept: assert property (@(posedge clock) disable iff (!resetn)
		(in_valid && is_letter) |=> ((out_char != '0) && (out_char <= last_letter)));

endmodule

`default_nettype wire

/* hdl/cipher_sequencer.sv */
`default_nettype none

`include "cipher_settings.svh"

module cipher_sequencer
(
	input  logic                clock,
	input  logic                resetn,
	input  logic                go,
	input  logic                decode,
	input  cipher_pkg::char_t   shift,
	input  cipher_pkg::str_t    str,
	output logic                busy,
	output logic                start,
	output logic                issue_valid,
	output cipher_pkg::slot_t   issue_slot,
	output cipher_pkg::char_t   issue_char,
	output cipher_pkg::opcode_t issue_op,
	output cipher_pkg::char_t   issue_amount
);
	import cipher_pkg::*;

	// Index of the final slot of a string.
	localparam slot_t last_slot = slot_t'(`CIPHER_STR_LEN - 1);

	// Alphabet size in character width.
	localparam char_t alpha = char_t'(`CIPHER_ALPHA);

	seq_state_t state;

	// Copy of the string taken when the run starts.
	str_t snap;

	// Shift amount folded into 0 to 25.
	char_t shift_mod;

	// Go is only taken when idle.
	logic go_accept;

	assign go_accept = go && (state == st_idle);

	// A 5-bit shift is at most 31, so one subtraction is enough.
	assign shift_mod = (shift >= alpha) ? shift - alpha : shift;

	// Run control.
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			state <= st_idle;
			issue_slot <= '0;
			start <= 1'b0;
		end
		else
		begin
			// Start pulses for the one cycle after the go edge.
			start <= go_accept;
			case (state)
				st_idle:
				begin
					if (go_accept)
					begin
						state <= st_run;
						issue_slot <= '0;
					end
				end
				st_run:
				begin
					// Step through the slots, then wait one cycle for the shifter.
					if (issue_slot == last_slot)
						state <= st_drain;
					else
						issue_slot <= issue_slot + 1'b1;
				end
				st_drain:
				begin
					state <= st_idle;
					issue_slot <= '0;
				end
				default:
				begin
					state <= st_idle;
				end
			endcase
		end
	end

	// Command decode and snapshot, held for the whole run.
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			snap <= '0;
			issue_op <= op_encode;
			issue_amount <= '0;
		end
		else if (go_accept)
		begin
			snap <= str;
			issue_op <= decode ? op_decode : op_encode;
			issue_amount <= shift_mod;
		end
	end

	assign busy = (state != st_idle);
	assign issue_valid = (state == st_run);
	assign issue_char = snap[issue_slot];

	// The slot counter stays inside the string.
	slot_in_range: assert property (@(posedge clock) disable iff (!resetn)
		issue_slot <= last_slot);

	// A go outside idle leaves the running command untouched.
	go_ignored_busy: assert property (@(posedge clock) disable iff (!resetn)
		(go && (state != st_idle)) |=>
		($stable(snap) && $stable(issue_op) && $stable(issue_amount)));

endmodule

`default_nettype wire

/* hdl/string_loader.sv */
`default_nettype none

`include "cipher_settings.svh"

module string_loader
(
	input  logic              clock,
	input  logic              resetn,
	input  logic              load,
	input  cipher_pkg::char_t char_in,
	output cipher_pkg::str_t  str
);
	import cipher_pkg::*;

	// Slot count of a full string.
	localparam slot_t full_count = slot_t'(`CIPHER_STR_LEN);

	// Next slot to be written.
	slot_t idx;

	// High while there is still an empty slot.
	logic has_room;

	assign has_room = (idx < full_count);

	// Fill the slots in order on each load strobe.
	// Once all five are filled, further loads are dropped.
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			idx <= '0;
			str <= '0;
		end
		else if (load && has_room)
		begin
			str[idx] <= char_in;
			idx <= idx + 1'b1;
		end
	end

	// The index stops at five and never wraps.
	idx_in_range: assert property (@(posedge clock) disable iff (!resetn)
		idx <= full_count);

endmodule

`default_nettype wire

/* hdl/cipher_pkg.sv */
`default_nettype none

`include "cipher_settings.svh"

package cipher_pkg;

	// One character code.
	typedef logic [`CIPHER_CHAR_W-1:0] char_t;

	// Five characters, slot 0 sits in the top bits.
	typedef char_t [0:`CIPHER_STR_LEN-1] str_t;

	// Slot index, wide enough to count past the last slot.
	typedef logic [2:0] slot_t;

	// Direction of the shift.
	typedef enum logic
	{
		op_encode = 1'b0,
		op_decode = 1'b1
	} opcode_t;

	// Output view selection.
	// Only the Caesar code shows the result, the others show the plain string.
	typedef enum logic [1:0]
	{
		method_plain    = 2'b00,
		method_caesar   = 2'b01,
		method_vigenere = 2'b10,
		method_spare    = 2'b11
	} method_t;

	// Run sequencer states.
	typedef enum logic [1:0]
	{
		st_idle  = 2'b00,
		st_run   = 2'b01,
		st_drain = 2'b10
	} seq_state_t;

endpackage

`default_nettype wire

/* hdl/cipher_settings.svh */
`ifndef CIPHER_SETTINGS_SVH
`define CIPHER_SETTINGS_SVH

// Width of one character code, also used for the shift amount.
// Codes 1 to 26 are the letters, 0 is an empty slot.
`define CIPHER_CHAR_W 5

// Number of character slots in one string.
`define CIPHER_STR_LEN 5

// Letters in the alphabet, the modulus of the shift.
`define CIPHER_ALPHA 26

// Width of a whole packed string.
`define CIPHER_STR_W 25

`endif
